//--- hdl/wb_bus_pkg.sv
// wishbone bus package holding the bus widths, the vector types and the master output bundle
package wb_bus_pkg;

    // ==============================
    // bus widths
    // ==============================
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // byte address, data word and byte-lane select as seen on the bus
    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // ==============================
    // master outputs
    // ==============================
    // everything the master drives onto the bus travels as one bundle
    typedef struct packed {
        wb_adr_t adr;
        wb_sel_t sel;
        logic    we;
        wb_dat_t dat;
        logic    cyc;
        logic    stb;
    } wb_out_t;

endpackage

//--- hdl/core_req_pkg.sv
// core request package with the cache request bundles, the source encoding and the bus states
package core_req_pkg;

    // instruction fetch request, always a read
    // the requester holds these fields until the cycle after its last ready pulse
    typedef struct packed {
        logic                req;
        logic                qword;
        wb_bus_pkg::wb_adr_t adr;
    } icache_req_t;

    // data cache request, cached and uncached share the remaining fields
    // sel is only meaningful for writes, reads always use every lane
    typedef struct packed {
        logic                cached_req;
        logic                uncached_req;
        logic                qword;
        logic                write;
        wb_bus_pkg::wb_sel_t sel;
        wb_bus_pkg::wb_adr_t adr;
        wb_bus_pkg::wb_dat_t dat;
    } dcache_req_t;

    // which requester owns the bus cycle in flight
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_ICACHE,
        SRC_DCACHE_CACHED,
        SRC_DCACHE_UNCACHED
    } req_src_t;

    // bus cycle sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_LAST_ACK
    } bus_state_t;

    // beat index inside a line, wide enough for a four-word line fill
    typedef logic [1:0] beat_t;

endpackage

//--- hdl/req_arbiter.sv
// request arbiter that picks the next cache request and steers ready pulses back to its source
`timescale 1ns/1ps

module req_arbiter (
    input  logic                      i_clk,
    input  logic                      quick_n_reset,
    input  core_req_pkg::icache_req_t i_icache,
    input  core_req_pkg::dcache_req_t i_dcache,
    input  logic                      i_start_ok,
    input  logic                      i_load,
    input  logic                      i_done,
    input  logic                      i_wb_ack,
    input  wb_bus_pkg::wb_dat_t       i_wb_dat,
    output logic                      o_start,
    output logic                      o_qword,
    output core_req_pkg::dcache_req_t o_sel_req,
    output logic                      o_icache_ready,
    output logic                      o_dcache_cached_ready,
    output logic                      o_dcache_uncached_ready,
    output wb_bus_pkg::wb_dat_t       o_read_data
);
    import wb_bus_pkg::*;
    import core_req_pkg::*;

    req_src_t pick_src;
    req_src_t served_src;
    logic     done_q;

    // ==============================
    // priority pick
    // ==============================
    // data cache wins over instruction fetch, cached wins over uncached
    always_comb
    begin
        if (i_dcache.cached_req)
            pick_src = SRC_DCACHE_CACHED;
        else if (i_dcache.uncached_req)
            pick_src = SRC_DCACHE_UNCACHED;
        else if (i_icache.req)
            pick_src = SRC_ICACHE;
        else
            pick_src = SRC_NONE;
    end

    // the chosen request in data cache shape, so the bus registers see a single format
    always_comb
    begin
        o_sel_req = i_dcache;
        o_qword   = i_dcache.qword;
        if (pick_src == SRC_ICACHE)
        begin
            // fetches are word aligned reads
            o_sel_req.adr   = {i_icache.adr[WB_ADR_W-1:2], 2'b00};
            o_sel_req.write = 1'b0;
            o_qword         = i_icache.qword;
        end
        // byte enables only matter for writes, a read takes the whole word
        if (!o_sel_req.write)
            o_sel_req.sel = '1;
    end

    // the served source still shows its old request in the cycle after done,
    // so that cycle must not start a new transfer
    assign o_start = (pick_src != SRC_NONE) && i_start_ok && !done_q;

    // ==============================
    // served source tracking
    // ==============================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            served_src <= SRC_NONE;
            done_q     <= 1'b0;
        end
        else
        begin
            done_q <= i_done;
            if (i_load)
                served_src <= pick_src;
            else if (i_done)
                served_src <= SRC_NONE;
        end
    end

    // every ack, read or write, pulses ready towards the owner only
    assign o_icache_ready          = i_wb_ack && (served_src == SRC_ICACHE);
    assign o_dcache_cached_ready   = i_wb_ack && (served_src == SRC_DCACHE_CACHED);
    assign o_dcache_uncached_ready = i_wb_ack && (served_src == SRC_DCACHE_UNCACHED);

    // read data is shared, each source qualifies it with its own ready
    assign o_read_data = i_wb_dat;

endmodule

//--- hdl/burst_counter.sv
// beat counter for a bus transfer that flags the beat before the last one of a line
`timescale 1ns/1ps

module burst_counter #(
    parameter int BURST_LEN = 4
) (
    input  logic                i_clk,
    input  logic                quick_n_reset,
    input  logic                i_load,
    input  logic                i_advance,
    output core_req_pkg::beat_t o_beat,
    output logic                o_last_beat
);
    import core_req_pkg::*;

    // index of the beat whose ack hands over to the final acknowledge
    localparam beat_t LAST_IDX = beat_t'(BURST_LEN - 2);

    beat_t beat_q;

    // cleared at the start of every transfer and stepped on each accepted burst beat
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            beat_q <= '0;
        else if (i_load)
            beat_q <= '0;
        else if (i_advance)
            beat_q <= beat_q + beat_t'(1);
    end

    assign o_beat      = beat_q;
    assign o_last_beat = (beat_q == LAST_IDX);

endmodule

//--- hdl/wb_cycle_fsm.sv
// bus cycle state machine that steps a transfer from idle through the burst beats to the final ack
`timescale 1ns/1ps

module wb_cycle_fsm #(
    parameter int BURST_LEN = 4
) (
    input  logic i_clk,
    input  logic quick_n_reset,
    input  logic i_start,
    input  logic i_qword,
    input  logic i_wb_ack,
    input  logic i_last_beat,
    output logic o_start_ok,
    output logic o_load,
    output logic o_advance,
    output logic o_done
);
    import core_req_pkg::*;

    bus_state_t state;
    bus_state_t state_nxt;

    // ==============================
    // state register
    // ==============================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // ==============================
    // next state and strobes
    // ==============================
    always_comb
    begin
        state_nxt = state;
        o_load    = 1'b0;
        o_advance = 1'b0;
        o_done    = 1'b0;
        case (state)
            ST_IDLE:
            begin
                if (i_start)
                begin
                    o_load = 1'b1;
                    // a one-word line would be a single transfer anyway
                    if (i_qword && (BURST_LEN > 1))
                        state_nxt = ST_BURST;
                    else
                        state_nxt = ST_LAST_ACK;
                end
            end
            ST_BURST:
            begin
                // each ack moves the address on, the one before the last leaves the burst
                if (i_wb_ack)
                begin
                    o_advance = 1'b1;
                    if (i_last_beat)
                        state_nxt = ST_LAST_ACK;
                end
            end
            ST_LAST_ACK:
            begin
                if (i_wb_ack)
                begin
                    o_done    = 1'b1;
                    state_nxt = ST_IDLE;
                end
            end
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    assign o_start_ok = (state == ST_IDLE);

endmodule

//--- hdl/wb_bus_regs.sv
// wishbone output registers with the byte-lane address decode and the wrapping burst address
`timescale 1ns/1ps

module wb_bus_regs (
    input  logic                      i_clk,
    input  logic                      quick_n_reset,
    input  logic                      i_load,
    input  logic                      i_advance,
    input  logic                      i_done,
    input  core_req_pkg::dcache_req_t i_sel_req,
    input  core_req_pkg::beat_t       i_beat,
    output wb_bus_pkg::wb_out_t       o_wb
);
    import wb_bus_pkg::*;
    import core_req_pkg::*;

    // word address bits that wrap inside a line sit just above the byte offset
    localparam int BEAT_W = $bits(beat_t);

    wb_adr_t adr_q;
    wb_sel_t sel_q;
    wb_dat_t dat_q;
    beat_t   start_word_q;
    beat_t   next_word;
    logic    we_q;
    logic    stb_q;
    logic    cyc_q;

    // single lanes give their own index, the upper half gives 2, all else stays aligned
    function automatic logic [1:0] lane_adr(input wb_sel_t sel);
        case (sel)
            4'b0010: lane_adr = 2'd1;
            4'b0100: lane_adr = 2'd2;
            4'b1000: lane_adr = 2'd3;
            4'b1100: lane_adr = 2'd2;
            default: lane_adr = 2'd0;
        endcase
    endfunction

    // beat i has just been acked, so the bus moves to word start + i + 1
    assign next_word = start_word_q + i_beat + beat_t'(1);

    // ==============================
    // payload registers
    // ==============================
    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            adr_q        <= {i_sel_req.adr[WB_ADR_W-1:2], lane_adr(i_sel_req.sel)};
            sel_q        <= i_sel_req.sel;
            dat_q        <= i_sel_req.dat;
            start_word_q <= i_sel_req.adr[BEAT_W+1:2];
        end
        else if (i_advance)
            adr_q[BEAT_W+1:2] <= next_word;
    end

    // cycle control, stb and cyc stay up for the whole line and drop after the last ack
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            we_q  <= 1'b0;
            stb_q <= 1'b0;
            cyc_q <= 1'b0;
        end
        else if (i_load)
        begin
            we_q  <= i_sel_req.write;
            stb_q <= 1'b1;
            cyc_q <= 1'b1;
        end
        else if (i_done)
        begin
            we_q  <= 1'b0;
            stb_q <= 1'b0;
            cyc_q <= 1'b0;
        end
    end

    assign o_wb = '{adr: adr_q, sel: sel_q, we: we_q, dat: dat_q, cyc: cyc_q, stb: stb_q};

endmodule

//--- hdl/a25_wb_master.sv
// wishbone master top that turns instruction and data cache requests into bus cycles
`timescale 1ns/1ps

module a25_wb_master #(
    parameter int BURST_LEN = 4
) (
    input  logic                      i_clk,
    input  logic                      quick_n_reset,
    input  core_req_pkg::icache_req_t i_icache,
    input  core_req_pkg::dcache_req_t i_dcache,
    input  wb_bus_pkg::wb_dat_t       i_wb_dat,
    input  logic                      i_wb_ack,
    output logic                      o_icache_ready,
    output logic                      o_dcache_cached_ready,
    output logic                      o_dcache_uncached_ready,
    output wb_bus_pkg::wb_dat_t       o_read_data,
    output wb_bus_pkg::wb_out_t       o_wb
);
    import core_req_pkg::*;

    // arbiter to state machine
    logic        start;
    logic        qword;
    logic        start_ok;
    // state machine strobes towards the datapath
    logic        load;
    logic        advance;
    logic        done;
    // counter feedback
    logic        last_beat;
    beat_t       beat;
    dcache_req_t sel_req;

    // ==============================
    // request side
    // ==============================
    req_arbiter u_req_arbiter (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache                (i_icache),
        .i_dcache                (i_dcache),
        .i_start_ok              (start_ok),
        .i_load                  (load),
        .i_done                  (done),
        .i_wb_ack                (i_wb_ack),
        .i_wb_dat                (i_wb_dat),
        .o_start                 (start),
        .o_qword                 (qword),
        .o_sel_req               (sel_req),
        .o_icache_ready          (o_icache_ready),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready),
        .o_read_data             (o_read_data)
    );

    // ==============================
    // bus side
    // ==============================
    wb_cycle_fsm #(.BURST_LEN(BURST_LEN)) u_wb_cycle_fsm (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_start       (start),
        .i_qword       (qword),
        .i_wb_ack      (i_wb_ack),
        .i_last_beat   (last_beat),
        .o_start_ok    (start_ok),
        .o_load        (load),
        .o_advance     (advance),
        .o_done        (done)
    );

    burst_counter #(.BURST_LEN(BURST_LEN)) u_burst_counter (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_load        (load),
        .i_advance     (advance),
        .o_beat        (beat),
        .o_last_beat   (last_beat)
    );

    wb_bus_regs u_wb_bus_regs (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_load        (load),
        .i_advance     (advance),
        .i_done        (done),
        .i_sel_req     (sel_req),
        .i_beat        (beat),
        .o_wb          (o_wb)
    );

endmodule

//--- tests/wb_master_properties.sv
// wishbone protocol and bus state machine assertions for the master
`timescale 1ns/1ps

module wb_master_properties (
    input logic                     i_clk,
    input logic                     quick_n_reset,
    input wb_bus_pkg::wb_out_t      i_wb,
    input logic                     i_wb_ack,
    input core_req_pkg::bus_state_t i_state
);
    import core_req_pkg::*;

    // ==============================
    // bus protocol
    // ==============================
    // a waiting request keeps its strobe, its cycle and its fields until the slave takes it
    hold_until_ack: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_wb.stb && !i_wb_ack) |=>
            (i_wb.stb && i_wb.cyc && $stable({i_wb.adr, i_wb.sel, i_wb.we, i_wb.dat})))
        else $error("bus request changed while waiting for an acknowledge");

    // ==============================
    // state sequencing
    // ==============================
    // a burst always hands over to the final acknowledge first
    burst_not_to_idle: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == ST_BURST) |=> (i_state != ST_IDLE))
        else $error("burst state went straight to idle");

    // the final acknowledge closes the transfer at the next edge
    last_ack_to_idle: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        ((i_state == ST_LAST_ACK) && i_wb_ack) |=> (i_state == ST_IDLE))
        else $error("final acknowledge did not return the state machine to idle");

endmodule

// the state lives in the state machine, stb and cyc only exist at the top level
bind a25_wb_master wb_master_properties u_wb_master_properties (
    .i_clk         (i_clk),
    .quick_n_reset (quick_n_reset),
    .i_wb          (o_wb),
    .i_wb_ack      (i_wb_ack),
    .i_state       (u_wb_cycle_fsm.state)
);

//--- tests/tb_wb_master.sv
// testbench for the wishbone master with a random-delay slave, a reference model and priority checks
`timescale 1ns/1ps

module tb_wb_master;
    import wb_bus_pkg::*;
    import core_req_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'he1c5;
    localparam int          NUM_RAND     = 30;
    localparam int          NUM_DIRECTED = 16;
    localparam int          MAX_ACK_WAIT = 3;
    // four beats with the longest wait each, plus start and the idle cycle, with margin
    localparam int          TXN_CYCLES   = 24;
    localparam int          WATCHDOG_NS  =
        (RESET_CYCLES + (NUM_RAND * 3 + NUM_DIRECTED) * TXN_CYCLES) * CLK_PERIOD;
    localparam wb_dat_t     DAT_MIX      = 32'h5a5a_c3c3;

    logic        clk;
    logic        quick_n_reset;
    icache_req_t icache;
    dcache_req_t dcache;
    wb_dat_t     wb_dat;
    logic        wb_ack;
    logic        icache_ready;
    logic        dcache_cached_ready;
    logic        dcache_uncached_ready;
    wb_dat_t     read_data;
    wb_out_t     wb;

    logic [31:0] stim_seed;
    logic [31:0] ack_seed;
    int          ack_wait;
    int          errors;
    int          stray_errors;
    int          checks;
    int          tests;
    int          err_mark;

    a25_wb_master #(.BURST_LEN(4)) DUT (
        .i_clk                   (clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache                (icache),
        .i_dcache                (dcache),
        .i_wb_dat                (wb_dat),
        .i_wb_ack                (wb_ack),
        .o_icache_ready          (icache_ready),
        .o_dcache_cached_ready   (dcache_cached_ready),
        .o_dcache_uncached_ready (dcache_uncached_ready),
        .o_read_data             (read_data),
        .o_wb                    (wb)
    );

    // ==============================
    // reference model
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1664525 + 32'd1013904223;
    endfunction

    // the low bits of an lcg are weak, so fold the upper half down
    function automatic logic [31:0] next_rand();
        stim_seed = lcg_next(stim_seed);
        next_rand = stim_seed ^ (stim_seed >> 16);
    endfunction

    // slave memory holds the word address mixed with a constant
    function automatic wb_dat_t slave_word(input wb_adr_t adr);
        slave_word = {adr[31:2], 2'b00} ^ DAT_MIX;
    endfunction

    // a lone lane gives its index, the upper half gives 2, anything else stays aligned
    function automatic logic [1:0] lane_offset(input wb_sel_t sel);
        logic [1:0] offset;
        offset = 2'd0;
        if ($countones(sel) == 1)
        begin
            for (int i = 0; i < 4; i++)
                if (sel[i])
                    offset = 2'(i);
        end
        else if (sel == 4'b1100)
            offset = 2'd2;
        lane_offset = offset;
    endfunction

    // word bits 3:2 step from the start word and wrap inside the line
    function automatic wb_adr_t beat_adr(input wb_adr_t adr, input int beat,
                                         input logic [1:0] offset);
        logic [1:0] word;
        word     = adr[3:2] + 2'(beat);
        beat_adr = {adr[31:4], word, offset};
    endfunction

    // SRC_NONE also stands for two or more ready outputs high at once
    function automatic req_src_t ready_src();
        case ({icache_ready, dcache_cached_ready, dcache_uncached_ready})
            3'b100:  ready_src = SRC_ICACHE;
            3'b010:  ready_src = SRC_DCACHE_CACHED;
            3'b001:  ready_src = SRC_DCACHE_UNCACHED;
            default: ready_src = SRC_NONE;
        endcase
    endfunction

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_dat(input wb_dat_t got, input wb_dat_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_adr(input wb_adr_t got, input wb_adr_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sel(input wb_sel_t got, input wb_sel_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_src(input req_src_t got, input req_src_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        $display("test %-28s %s, %0d errors", name, (errors == mark) ? "ok" : "mismatch",
                 errors - mark);
    endtask

    // ==============================
    // request side
    // ==============================
    task automatic drive_icache(input logic qword, input wb_adr_t adr);
        icache = '{req: 1'b1, qword: qword, adr: adr};
    endtask

    task automatic drive_dcache(input logic cached, input logic uncached, input logic qword,
                                input logic write, input wb_sel_t sel, input wb_adr_t adr,
                                input wb_dat_t dat);
        dcache = '{cached_req: cached, uncached_req: uncached, qword: qword, write: write,
                   sel: sel, adr: adr, dat: dat};
    endtask

    // follow one transfer to its end and check every acknowledged beat against the model
    task automatic follow_transfer(input req_src_t src, input logic qword, input logic write,
                                   input wb_sel_t sel, input wb_adr_t adr, input wb_dat_t dat);
        int         beats;
        wb_sel_t    exp_sel;
        logic [1:0] offset;
        wb_adr_t    exp_adr;
        beats   = qword ? 4 : 1;
        exp_sel = write ? sel : 4'hf;
        offset  = write ? lane_offset(sel) : 2'd0;
        for (int b = 0; b < beats; b++)
        begin
            // outputs are settled by the falling edge, each ack lasts exactly one cycle
            @(negedge clk);
            while (!wb_ack)
                @(negedge clk);
            exp_adr = beat_adr(adr, b, offset);
            check_adr(wb.adr, exp_adr, "bus address");
            check_sel(wb.sel, exp_sel, "bus select");
            check_flag(wb.we, write, "bus write enable");
            check_flag(wb.cyc, 1'b1, "bus cycle");
            check_src(ready_src(), src, "ready output");
            if (write)
                check_dat(wb.dat, dat, "write data");
            else
                check_dat(read_data, slave_word(exp_adr), "read data");
        end
        // the bus cycle closes at the edge after the last acknowledge
        @(posedge clk);
        #1;
        check_flag(wb.stb, 1'b0, "stb after last ack");
        check_flag(wb.cyc, 1'b0, "cyc after last ack");
        check_flag(wb.we, 1'b0, "we after last ack");
        // the source lets go in the cycle after its last ready pulse
        if (src == SRC_ICACHE)
            icache.req = 1'b0;
        else if (src == SRC_DCACHE_CACHED)
            dcache.cached_req = 1'b0;
        else
            dcache.uncached_req = 1'b0;
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic idle_after_reset();
        repeat (4)
        begin
            @(negedge clk);
            check_flag(wb.stb, 1'b0, "stb after reset");
            check_flag(wb.cyc, 1'b0, "cyc after reset");
            check_flag(wb.we, 1'b0, "we after reset");
            check_src(ready_src(), SRC_NONE, "ready outputs after reset");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic data_writes();
        wb_sel_t lanes [7];
        wb_adr_t adr;
        wb_dat_t dat;
        lanes = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1100, 4'b0011, 4'b1111};
        for (int k = 0; k < 7; k++)
        begin
            adr = 32'h0000_4000 + 32'(k * 8);
            dat = 32'hc0de_0000 + 32'(k);
            // alternate between the cached and the uncached path
            drive_dcache(k[0], !k[0], 1'b0, 1'b1, lanes[k], adr, dat);
            follow_transfer(k[0] ? SRC_DCACHE_CACHED : SRC_DCACHE_UNCACHED, 1'b0, 1'b1,
                            lanes[k], adr, dat);
        end
    endtask

    // all three sources pending together are served cached, uncached, then fetch
    task automatic pending_priority();
        drive_icache(1'b1, 32'h0000_8004);
        drive_dcache(1'b1, 1'b1, 1'b1, 1'b0, 4'hf, 32'h0000_9008, '0);
        follow_transfer(SRC_DCACHE_CACHED, 1'b1, 1'b0, 4'hf, 32'h0000_9008, '0);
        follow_transfer(SRC_DCACHE_UNCACHED, 1'b1, 1'b0, 4'hf, 32'h0000_9008, '0);
        follow_transfer(SRC_ICACHE, 1'b1, 1'b0, 4'hf, 32'h0000_8004, '0);
    endtask

    // a random subset of sources raised at once, the model serves them by priority
    task automatic random_round();
        logic [31:0] r;
        logic [2:0]  mask;
        wb_adr_t     fetch_adr;
        wb_adr_t     d_adr;
        wb_dat_t     d_dat;
        wb_sel_t     d_sel;
        r         = next_rand();
        fetch_adr = next_rand();
        d_adr     = next_rand();
        d_dat     = next_rand();
        mask      = (r[2:0] == 3'b000) ? 3'b001 : r[2:0];
        d_sel     = (r[4] && (r[9:6] != 4'h0)) ? r[9:6] : 4'hf;
        icache    = '{req: mask[0], qword: r[3], adr: fetch_adr};
        drive_dcache(mask[1], mask[2], r[5] && !r[4], r[4], d_sel, d_adr, d_dat);
        if (mask[1])
            follow_transfer(SRC_DCACHE_CACHED, r[5] && !r[4], r[4], d_sel, d_adr, d_dat);
        if (mask[2])
            follow_transfer(SRC_DCACHE_UNCACHED, r[5] && !r[4], r[4], d_sel, d_adr, d_dat);
        if (mask[0])
            follow_transfer(SRC_ICACHE, r[3], 1'b0, 4'hf, fetch_adr, '0);
    endtask

    // ==============================
    // clock, slave and monitors
    // ==============================
    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // slave acks only while stb is high, after 0 to MAX_ACK_WAIT wait cycles
    initial
    begin
        wb_ack   = 1'b0;
        wb_dat   = '0;
        ack_seed = lcg_next(SEED);
        ack_wait = 0;
        forever
        begin
            @(posedge clk);
            #1;
            wb_ack = 1'b0;
            if (quick_n_reset && wb.stb)
            begin
                if (ack_wait == 0)
                begin
                    wb_ack   = 1'b1;
                    wb_dat   = slave_word(wb.adr);
                    ack_seed = lcg_next(ack_seed);
                    ack_wait = int'(ack_seed[23:16]) % (MAX_ACK_WAIT + 1);
                end
                else
                    ack_wait--;
            end
        end
    end

    // no source may see a ready pulse unless the bus acknowledged
    always @(negedge clk)
    begin
        if (!wb_ack && (icache_ready || dcache_cached_ready || dcache_uncached_ready))
        begin
            stray_errors++;
            $display("error at %0t ns: a ready pulse came without a bus acknowledge", $time);
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns, the transfers never completed", $time);
        $display("Testbench failed");
        $finish;
    end

    // ==============================
    // main sequence
    // ==============================
    initial
    begin
        errors        = 0;
        stray_errors  = 0;
        checks        = 0;
        tests         = 0;
        stim_seed     = SEED;
        quick_n_reset = 1'b0;
        icache        = '0;
        dcache        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        quick_n_reset = 1'b1;

        err_mark = errors;
        idle_after_reset();
        report_test("idle after reset", err_mark);

        err_mark = errors;
        drive_icache(1'b0, 32'h0000_1236);
        follow_transfer(SRC_ICACHE, 1'b0, 1'b0, 4'hf, 32'h0000_1236, '0);
        report_test("instruction single read", err_mark);

        // start word 2 with a stray byte offset, so the line wraps 2-3-0-1
        err_mark = errors;
        drive_icache(1'b1, 32'h0000_204a);
        follow_transfer(SRC_ICACHE, 1'b1, 1'b0, 4'hf, 32'h0000_204a, '0);
        report_test("instruction line fill", err_mark);

        err_mark = errors;
        drive_dcache(1'b1, 1'b0, 1'b1, 1'b0, 4'h1, 32'h0000_303c, '0);
        follow_transfer(SRC_DCACHE_CACHED, 1'b1, 1'b0, 4'h1, 32'h0000_303c, '0);
        drive_dcache(1'b0, 1'b1, 1'b1, 1'b0, 4'hf, 32'h0000_3104, '0);
        follow_transfer(SRC_DCACHE_UNCACHED, 1'b1, 1'b0, 4'hf, 32'h0000_3104, '0);
        report_test("data line reads", err_mark);

        err_mark = errors;
        data_writes();
        report_test("data writes and lanes", err_mark);

        err_mark = errors;
        pending_priority();
        report_test("request priority", err_mark);

        err_mark = errors;
        for (int n = 0; n < NUM_RAND; n++)
            random_round();
        report_test("random rounds", err_mark);

        errors = errors + stray_errors;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb.f
hdl/wb_bus_pkg.sv
hdl/core_req_pkg.sv
hdl/req_arbiter.sv
hdl/burst_counter.sv
hdl/wb_cycle_fsm.sv
hdl/wb_bus_regs.sv
hdl/a25_wb_master.sv
tests/wb_master_properties.sv
tests/tb_wb_master.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_wb_master -f tb.f -o sim_tb_wb_master &&
./obj_dir/sim_tb_wb_master | tee /dev/stderr | grep -q "Testbench passed" &&
echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }
